/* sifhHistTop.f */
+incdir+include
verilog/sifhTypesPkg.sv
verilog/sifhCtrlPkg.sv
verilog/histRam.sv
verilog/binIncrementer.sv
verilog/peakFinder.sv
verilog/sifhHistCtrl.sv
verilog/sifhHistTop.sv
dv/sifhHist_props.sv
dv/sifhHistTb.sv

/* Makefile */
# Verilator build and run of the histogrammer testbench

VERILATOR ?= verilator
TOP       ?= sifhHistTb
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
OBJDIR    ?= obj_dir
FILELIST  := sifhHistTop.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

/* dv/sifhHistTb.sv */
`include "sifh_config.svh"

module sifhHistTb;
    timeunit 1ns;
    timeprecision 100ps;

    import sifhTypesPkg::*;

    localparam int ClkPeriod = 40;
    localparam int NumBins = 1 << `SIFH_NB;
    localparam int MaxCount = (1 << `SIFH_PEAKMAX) - 1;
    localparam int BinLsb = `SIFH_NP - `SIFH_NB;
    localparam int ReportLatency = NumBins + 4;  // frameEnd edge to peakValid edge
    localparam int NumFrames = 7;
    localparam int StimCycles = 1300;            // bound on all sample phases
    localparam int TimeoutCycles = 2 * (StimCycles + NumFrames * (ReportLatency + 4));
    localparam logic [31:0] LfsrTaps = 32'h8020_0003;

    logic        clk;
    logic        res;
    logic        sampleValid;
    logic        frameEnd;
    sample_t     sample;
    logic        busy;
    logic        peakValid;
    peakResult_t peak;

    logic [31:0] lfsrState = 32'h3772_491e;
    int          modelHist [NumBins];   // hits of the open frame, not clamped
    int          cycleCnt = 0;
    int          framesSent = 0;
    int          reportsSeen = 0;
    peakResult_t expPeak [$];
    int          expStart [$];          // cycle of the edge that takes frameEnd
    bit          expChecked [$];

    sifhHistTop UUT (
        .clk        (clk),
        .res        (res),
        .sampleValid(sampleValid),
        .frameEnd   (frameEnd),
        .sample     (sample),
        .busy       (busy),
        .peakValid  (peakValid),
        .peak       (peak)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // galois lfsr, one step per bit
    function automatic int unsigned randBits(input int n);
        int unsigned value;
        logic        fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (fb) begin
                lfsrState = lfsrState ^ LfsrTaps;
            end
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // highest clamped count, first bin keeps a tie
    function automatic peakResult_t refPeak();
        peakResult_t best;
        int          clamped;
        best.bin = '0;
        best.count = '0;
        for (int b = 0; b < NumBins; b++) begin
            clamped = (modelHist[b] > MaxCount) ? MaxCount : modelHist[b];
            if (clamped > int'(best.count)) begin
                best.bin = binAddr_t'(b);
                best.count = binCount_t'(clamped);
            end
        end
        return best;
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkBin(input string name, input binAddr_t exp, input binAddr_t act);
        if (act !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act));
        end
    endtask

    task automatic checkCount(input string name, input binCount_t exp, input binCount_t act);
        if (act !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act));
        end
    endtask

    task automatic checkCycles(input string name, input int exp, input int act);
        if (act != exp) begin
            failRun($sformatf("Mismatch at %0t: %s expected %0d cycles, got %0d", $time, name,
                              exp, act));
        end
    endtask

    task automatic checkLevel(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            failRun($sformatf("Mismatch at %0t: %s expected %0b, got %0b", $time, name,
                              exp, act));
        end
    endtask

    task automatic driveSample(input binAddr_t bin, input bit counted);
        sample_t s;
        s = sample_t'(randBits(BinLsb));  // random fine bits below the bin
        s[`SIFH_NP-1:BinLsb] = bin;
        @(negedge clk);
        sampleValid = 1'b1;
        sample = s;
        frameEnd = 1'b0;
        if (counted) begin
            modelHist[bin] = modelHist[bin] + 1;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            sampleValid = 1'b0;
            frameEnd = 1'b0;
        end
    endtask

    task automatic endFrame(input bit checked);
        @(negedge clk);
        sampleValid = 1'b0;
        frameEnd = 1'b1;
        expPeak.push_back(refPeak());
        expStart.push_back(cycleCnt + 1);
        expChecked.push_back(checked);
        framesSent++;
        foreach (modelHist[b]) modelHist[b] = 0;  // next frame starts empty
    endtask

    task automatic awaitReport();
        idle(1);
        wait (reportsSeen == framesSent);
    endtask

    // compare each report against the queued reference
    initial begin
        peakResult_t expected;
        int          start;
        bit          checked;
        forever begin
            @(negedge clk);
            if (peakValid) begin
                if (expPeak.size() == 0) begin
                    failRun("peakValid pulsed with no frame end pending");
                end else begin
                    expected = expPeak.pop_front();
                    start = expStart.pop_front();
                    checked = expChecked.pop_front();
                    checkCycles("peakValid latency", ReportLatency, cycleCnt - start);
                    checkLevel("busy", 1'b0, busy);
                    if (checked) begin
                        checkBin("peak.bin", expected.bin, peak.bin);
                        checkCount("peak.count", expected.count, peak.count);
                    end
                    reportsSeen++;
                end
            end
        end
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        failRun($sformatf("Timeout after %0d cycles, only %0d of %0d frames reported",
                          TimeoutCycles, reportsSeen, framesSent));
    end

    initial begin
        binAddr_t b;
        int       run;
        res = 1'b0;
        sampleValid = 1'b0;
        frameEnd = 1'b0;
        sample = '0;
        foreach (modelHist[i]) modelHist[i] = 0;
        repeat (2) @(negedge clk);
        res = 1'b1;
        checkLevel("busy", 1'b0, busy);
        checkLevel("peakValid", 1'b0, peakValid);

        endFrame(1'b0);  // scan clears the RAM, result unknown
        awaitReport();

        repeat (200) begin  // random bins with random gaps
            driveSample(binAddr_t'(randBits(`SIFH_NB)), 1'b1);
            idle(int'(randBits(2)));
        end
        endFrame(1'b1);
        awaitReport();

        repeat (30) begin  // runs of up to three to neighbouring bins
            b = binAddr_t'(20 + randBits(2));
            run = 1 + int'(randBits(2) % 3);
            repeat (run) driveSample(b, 1'b1);
        end
        endFrame(1'b1);
        awaitReport();

        repeat (300) driveSample(binAddr_t'(33), 1'b1);  // beyond the count range
        repeat (20) driveSample(binAddr_t'(2), 1'b1);
        endFrame(1'b1);
        awaitReport();

        repeat (6) begin  // equal top counts in bins 50 and 12
            driveSample(binAddr_t'(50), 1'b1);
            driveSample(binAddr_t'(12), 1'b1);
            idle(1);
        end
        repeat (4) begin
            driveSample(binAddr_t'(3), 1'b1);
            driveSample(binAddr_t'(60), 1'b1);
        end
        endFrame(1'b1);
        awaitReport();

        endFrame(1'b1);  // empty frame
        repeat (30) driveSample(binAddr_t'(randBits(`SIFH_NB)), 1'b0);  // dropped while busy
        awaitReport();

        repeat (5) driveSample(binAddr_t'(7), 1'b1);
        idle(2);
        repeat (3) driveSample(binAddr_t'(63), 1'b1);
        endFrame(1'b1);
        awaitReport();
        idle(4);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* dv/sifhHist_props.sv */
`include "sifh_config.svh"

module sifhHistProps (
    input logic                  clk,
    input logic                  res,
    input logic                  frameEnd,
    input logic                  busy,
    input logic                  peakValid,
    input sifhCtrlPkg::ramRead_t incRd,
    input sifhCtrlPkg::ramRead_t ramRd
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumBins = 1 << `SIFH_NB;
    localparam int ReportCycles = NumBins + 4;  // frameEnd edge to peakValid edge

    int sinceEnd;  // cycles since the edge that took frameEnd

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sinceEnd <= 0;
        end else if (frameEnd && !busy) begin
            sinceEnd <= 1;
        end else if ((sinceEnd != 0) && (sinceEnd < ReportCycles)) begin
            sinceEnd <= sinceEnd + 1;
        end else begin
            sinceEnd <= 0;
        end
    end

    peakPulse: assert property (@(posedge clk) disable iff (!res) peakValid |=> !peakValid)
        else $error("peakValid high for more than one cycle");

    // busy covers drain, scan and report
    busyWindow: assert property (@(posedge clk) disable iff (!res)
                                 busy == (sinceEnd != 0))
        else $error("busy does not follow the frame end sequence");

    // pipeline read means a sample was taken
    acceptIdle: assert property (@(posedge clk) disable iff (!res)
                                 incRd.en |-> (sinceEnd == 0))
        else $error("sample accepted while busy");

    // two drain cycles, then one read per bin
    scanWindow: assert property (@(posedge clk) disable iff (!res)
                                 (ramRd.en && !incRd.en) ==
                                 ((sinceEnd > 2) && (sinceEnd <= NumBins + 2)))
        else $error("scan read outside the scan phase");

endmodule

bind sifhHistTop sifhHistProps props (
    .clk      (clk),
    .res      (res),
    .frameEnd (frameEnd),
    .busy     (busy),
    .peakValid(peakValid),
    .incRd    (incRd),
    .ramRd    (ramRd)
);

/* verilog/sifhHistTop.sv */
module sifhHistTop (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      sampleValid,
    input  logic                      frameEnd,
    input  sifhTypesPkg::sample_t     sample,
    output logic                      busy,
    output logic                      peakValid,
    output sifhTypesPkg::peakResult_t peak
);
    import sifhTypesPkg::*;
    import sifhCtrlPkg::*;

    ramWrite_t incWr;     // pipeline write request
    ramRead_t  incRd;     // pipeline read request
    ramWrite_t ramWr;
    ramRead_t  ramRd;
    binCount_t rdData;
    logic      accept;
    logic      pipeBusy;
    logic      scanValid;
    logic      scanLast;

    sifhHistCtrl ctrl (
        .clk        (clk),
        .res        (res),
        .sampleValid(sampleValid),
        .frameEnd   (frameEnd),
        .pipeBusy   (pipeBusy),
        .incWr      (incWr),
        .incRd      (incRd),
        .accept     (accept),
        .ramWr      (ramWr),
        .ramRd      (ramRd),
        .scanValid  (scanValid),
        .scanLast   (scanLast),
        .busy       (busy)
    );

    histRam ram (
        .clk   (clk),
        .wr    (ramWr),
        .rd    (ramRd),
        .rdData(rdData)
    );

    binIncrementer inc (
        .clk        (clk),
        .res        (res),
        .accept     (accept),
        .sampleValid(sampleValid),
        .sample     (sample),
        .rdData     (rdData),
        .rd         (incRd),
        .wr         (incWr),
        .pipeBusy   (pipeBusy)
    );

    peakFinder finder (
        .clk      (clk),
        .res      (res),
        .scanValid(scanValid),
        .scanLast (scanLast),
        .rdData   (rdData),
        .peakValid(peakValid),
        .peak     (peak)
    );

endmodule

/* verilog/sifhHistCtrl.sv */
module sifhHistCtrl (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   sampleValid,
    input  logic                   frameEnd,
    input  logic                   pipeBusy,
    input  sifhCtrlPkg::ramWrite_t incWr,
    input  sifhCtrlPkg::ramRead_t  incRd,
    output logic                   accept,
    output sifhCtrlPkg::ramWrite_t ramWr,
    output sifhCtrlPkg::ramRead_t  ramRd,
    output logic                   scanValid,
    output logic                   scanLast,
    output logic                   busy
);
    import sifhTypesPkg::*;
    import sifhCtrlPkg::*;

    histState_t state;
    histState_t stateNext;
    binAddr_t   scanAddr;   // bin read and cleared this cycle
    logic       waitCnt;    // second cycle of drain or report

    assign accept = (state == IDLE) || (state == ACCUM);
    assign busy = !accept;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (frameEnd) begin
                    stateNext = DRAIN;
                end else if (sampleValid) begin
                    stateNext = ACCUM;
                end
            end
            ACCUM: begin
                if (frameEnd) begin
                    stateNext = DRAIN;
                end
            end
            DRAIN: begin
                if (waitCnt) begin  // last increment lands on this edge
                    stateNext = SCAN;
                end
            end
            SCAN: begin
                if (scanAddr == '1) begin
                    stateNext = REPORT;
                end
            end
            REPORT: begin
                if (waitCnt) begin  // peak finder registers its result now
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            waitCnt <= 1'b0;
            scanAddr <= '0;
            scanValid <= 1'b0;
            scanLast <= 1'b0;
        end else begin
            state <= stateNext;
            waitCnt <= ((state == DRAIN) || (state == REPORT)) ? !waitCnt : 1'b0;
            scanAddr <= (state == SCAN) ? scanAddr + 1'b1 : '0;
            // one cycle late, lined up with the registered RAM data
            scanValid <= (state == SCAN);
            scanLast <= (state == SCAN) && (scanAddr == '1);
        end
    end

    // port selection
    always_comb begin
        ramRd = incRd;
        if (state == SCAN) begin
            ramRd.en = 1'b1;
            ramRd.addr = scanAddr;
        end
        ramWr = incWr;
        if (!pipeBusy) begin  // pipeline owns the write port while it holds items
            ramWr.en = (state == SCAN);
            ramWr.addr = scanAddr;
            ramWr.data = '0;  // clear behind the read
        end
    end

endmodule

/* verilog/peakFinder.sv */
module peakFinder (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      scanValid,
    input  logic                      scanLast,
    input  sifhTypesPkg::binCount_t   rdData,
    output logic                      peakValid,
    output sifhTypesPkg::peakResult_t peak
);
    import sifhTypesPkg::*;

    binAddr_t  binIdx;     // bin of the count on rdData
    binAddr_t  bestBin;
    binCount_t bestCount;
    logic      lastSeen;   // best now covers every bin

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binIdx <= '0;
            lastSeen <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            lastSeen <= scanValid && scanLast;
            peakValid <= lastSeen;
            if (scanValid) begin
                binIdx <= scanLast ? '0 : binIdx + 1'b1;
            end
        end
    end

    // running max, strictly greater so the lower bin keeps a tie
    always_ff @(posedge clk) begin
        if (scanValid && ((binIdx == '0) || (rdData > bestCount))) begin
            bestBin <= binIdx;
            bestCount <= rdData;
        end
        if (lastSeen) begin
            peak <= '{bin: bestBin, count: bestCount};
        end
    end

endmodule

/* verilog/binIncrementer.sv */
`include "sifh_config.svh"

module binIncrementer (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    accept,
    input  logic                    sampleValid,
    input  sifhTypesPkg::sample_t   sample,
    input  sifhTypesPkg::binCount_t rdData,
    output sifhCtrlPkg::ramRead_t   rd,
    output sifhCtrlPkg::ramWrite_t  wr,
    output logic                    pipeBusy
);
    import sifhTypesPkg::*;

    localparam int BinLsb = `SIFH_NP - `SIFH_NB;

    binAddr_t  sampleBin;
    logic      s1Valid;     // read issued last cycle
    binAddr_t  s1Bin;
    logic      wrEn;        // write stage
    binAddr_t  wrAddr;
    binCount_t wrData;
    logic      doneValid;   // count written on the last edge
    binAddr_t  doneAddr;
    binCount_t doneData;
    binCount_t baseCount;
    binCount_t nextCount;

    assign sampleBin = sample[`SIFH_NP-1:BinLsb];
    assign rd = '{en: accept && sampleValid, addr: sampleBin};
    assign wr = '{en: wrEn, addr: wrAddr, data: wrData};
    assign pipeBusy = s1Valid || wrEn;

    // stage 1, pick the freshest count for the bin
    always_comb begin
        baseCount = rdData;
        if (doneValid && (doneAddr == s1Bin)) begin
            baseCount = doneData;  // written while our read was in flight
        end
        if (wrEn && (wrAddr == s1Bin)) begin
            baseCount = wrData;    // newest, not yet in RAM
        end
        nextCount = (baseCount == '1) ? baseCount : baseCount + 1'b1;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            wrEn <= 1'b0;
            doneValid <= 1'b0;
        end else begin
            s1Valid <= accept && sampleValid;
            wrEn <= s1Valid;
            doneValid <= wrEn;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= sampleBin;
        wrAddr <= s1Bin;
        wrData <= nextCount;
        doneAddr <= wrAddr;
        doneData <= wrData;
    end

endmodule

/* verilog/histRam.sv */
`include "sifh_config.svh"

module histRam (
    input  logic                    clk,
    input  sifhCtrlPkg::ramWrite_t  wr,
    input  sifhCtrlPkg::ramRead_t   rd,
    output sifhTypesPkg::binCount_t rdData
);
    import sifhTypesPkg::*;

    localparam int NumBins = 1 << `SIFH_NB;

    binCount_t mem [NumBins];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, same-address write returns the old count
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdData <= mem[rd.addr];
        end
    end

endmodule

/* verilog/sifhCtrlPkg.sv */
package sifhCtrlPkg;

    // frame sequence of the controller
    typedef enum logic [2:0] {
        IDLE,    // empty frame, waiting for hits
        ACCUM,   // frame holds hits
        DRAIN,   // increment pipeline flushing
        SCAN,    // read and clear every bin
        REPORT   // peak search finishing
    } histState_t;

    // histogram RAM write port
    typedef struct packed {
        logic                   en;
        sifhTypesPkg::binAddr_t  addr;
        sifhTypesPkg::binCount_t data;
    } ramWrite_t;

    // histogram RAM read port, data returns one cycle later
    typedef struct packed {
        logic                  en;
        sifhTypesPkg::binAddr_t addr;
    } ramRead_t;

endpackage

/* verilog/sifhTypesPkg.sv */
`include "sifh_config.svh"

package sifhTypesPkg;

    // raw time code as delivered with the sample strobe
    typedef logic [`SIFH_NP-1:0] sample_t;

    // histogram bin index, upper bits of a sample
    typedef logic [`SIFH_NB-1:0] binAddr_t;

    // per-bin hit count, saturating
    typedef logic [`SIFH_PEAKMAX-1:0] binCount_t;

    // reported result of one frame
    typedef struct packed {
        binAddr_t  bin;    // winning bin, lowest on a tie
        binCount_t count;  // its count
    } peakResult_t;

endpackage

/* include/sifh_config.svh */
`ifndef SIFH_CONFIG_SVH
`define SIFH_CONFIG_SVH

// width of the raw time code from the channel
`define SIFH_NP 10

// bin index width, the top bits of the time code
`define SIFH_NB 6

// bin counter width, counts hold at all ones
`define SIFH_PEAKMAX 8

`endif
